// ==== verilog/mpu_cfg.svh ====
//////////////////////////////
// MPU configuration
// PMA region table and bus limits
//////////////////////////////
`ifndef MPU_CFG_SVH
`define MPU_CFG_SVH

// Number of PMA regions in the table
`define MPU_NUM_REGIONS 32'd4

// Region bounds are word addresses, high bound is exclusive
// Attribute bits are {main, bufferable, cacheable, atomic}

// Region 0 covers 0x0000_0000 to 0x0000_4000 as main memory with all attributes
`define MPU_R0_LOW  30'h0000_0000
`define MPU_R0_HIGH 30'h0000_1000
`define MPU_R0_ATTR 4'b1111

// Region 1 covers 0x0000_2000 to 0x0000_8000 as main memory that is not cacheable
`define MPU_R1_LOW  30'h0000_0800
`define MPU_R1_HIGH 30'h0000_2000
`define MPU_R1_ATTR 4'b1101

// Region 2 covers 0x1000_0000 to 0x1000_1000 as bufferable I/O
`define MPU_R2_LOW  30'h0400_0000
`define MPU_R2_HIGH 30'h0400_0400
`define MPU_R2_ATTR 4'b0100

// Region 3 covers 0x2000_0000 to 0x2001_0000 as plain I/O
`define MPU_R3_LOW  30'h0800_0000
`define MPU_R3_HIGH 30'h0800_4000
`define MPU_R3_ATTR 4'b0000

// Bus transactions allowed to wait for a response
`define MPU_MAX_OUTSTANDING 2'd2

`endif

// ==== verilog/mpu_pkg.sv ====
//////////////////////////////
// MPU package
// Attribute, transaction and FSM types
//////////////////////////////
package mpu_pkg;

  ////////////////////////////// 
  // PMA types
  //////////////////////////////

  // Region attributes packed MSB first
  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
    logic atomic;
  } pma_attr_t;

  // One region with bounds in word addresses
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    pma_attr_t   attr;
  } pma_region_t;

  //////////////////////////////
  // Channel types
  //////////////////////////////

  // Core side request with size 0 byte, 1 half, 2 word
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [1:0]  size;
    logic        exec;
    logic        atomic;
  } core_trans_t;

  // Bus side request with memtype as {cacheable, bufferable}
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [1:0]  size;
    logic [1:0]  memtype;
  } bus_trans_t;

  // Response shared by bus and core
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mpu_resp_t;

  // Error FSM
  typedef enum logic {MPU_IDLE, MPU_ERR_WAIT} mpu_state_e;
  typedef enum logic {MPU_OK, MPU_ERR} mpu_status_e;

endpackage

// ==== verilog/pma_lookup.sv ====
//////////////////////////////
// PMA lookup
// Region match and access check
//////////////////////////////
`timescale 1ns/1ps
`include "mpu_cfg.svh"

module pma_lookup (
  input  logic [31:0]        addr_i,
  input  logic [1:0]         size_i,
  input  logic               exec_i,
  input  logic               atomic_i,
  output mpu_pkg::pma_attr_t attr_o,
  output logic               pma_err_o
);

  import mpu_pkg::*;

  //////////////////////////////
  // Region table
  //////////////////////////////

  localparam pma_region_t REGION_TABLE [`MPU_NUM_REGIONS] = '{
    '{word_addr_low: `MPU_R0_LOW, word_addr_high: `MPU_R0_HIGH, attr: `MPU_R0_ATTR},
    '{word_addr_low: `MPU_R1_LOW, word_addr_high: `MPU_R1_HIGH, attr: `MPU_R1_ATTR},
    '{word_addr_low: `MPU_R2_LOW, word_addr_high: `MPU_R2_HIGH, attr: `MPU_R2_ATTR},
    '{word_addr_low: `MPU_R3_LOW, word_addr_high: `MPU_R3_HIGH, attr: `MPU_R3_ATTR}
  };

  // Unmapped addresses behave as I/O with no attributes
  localparam pma_attr_t ATTR_DEFAULT = '0;

  logic [29:0] word_addr;
  pma_attr_t   region_attr;
  logic        misaligned;

  assign word_addr = addr_i[31:2];

  //////////////////////////////
  // Lowest index match
  //////////////////////////////

  always_comb begin
    region_attr = ATTR_DEFAULT;
    // Walk down so the lowest matching region is the last one applied
    for (int i = `MPU_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((word_addr >= REGION_TABLE[i].word_addr_low) &&
          (word_addr <  REGION_TABLE[i].word_addr_high)) begin
        region_attr = REGION_TABLE[i].attr;
      end
    end
  end

  assign attr_o = region_attr;

  //////////////////////////////
  // Access check
  //////////////////////////////

  // Alignment against the access size
  always_comb begin
    case (size_i)
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = addr_i[0];
      default: misaligned = |addr_i[1:0];
    endcase
  end

  // Fetch and misaligned access need main memory,
  // atomics need the atomic attribute
  assign pma_err_o = (exec_i     && !attr_o.main)   ||
                     (misaligned && !attr_o.main)   ||
                     (atomic_i   && !attr_o.atomic);

endmodule

// ==== verilog/mpu_err_fsm.sv ====
//////////////////////////////
// MPU error FSM
// Outstanding count and error response
//////////////////////////////
`timescale 1ns/1ps
`include "mpu_cfg.svh"

module mpu_err_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 core_trans_valid_i,
  input  logic                 core_trans_ready_i,
  input  logic                 bus_trans_valid_i,
  input  logic                 bus_trans_ready_i,
  input  logic                 bus_resp_valid_i,
  input  logic                 pma_err_i,
  output mpu_pkg::mpu_state_e  state_o,
  output mpu_pkg::mpu_status_e mpu_status_o,
  output logic                 mpu_err_trans_valid_o,
  output logic                 mpu_block_core_o,
  output logic                 mpu_block_bus_o
);

  import mpu_pkg::*;

  mpu_state_e state_q;
  mpu_state_e state_d;
  logic [1:0] outstanding_q;
  logic [1:0] outstanding_d;
  logic       core_accept;
  logic       bus_accept;
  logic       at_limit;
  logic       drained;

  assign core_accept = core_trans_valid_i && core_trans_ready_i;
  assign bus_accept  = bus_trans_valid_i && bus_trans_ready_i;
  assign at_limit    = (outstanding_q == `MPU_MAX_OUTSTANDING);
  assign drained     = (outstanding_q == 2'd0);

  //////////////////////////////
  // Outstanding responses
  //////////////////////////////

  // One in-order response comes back for each accepted bus request
  always_comb begin
    case ({bus_accept, bus_resp_valid_i})
      2'b10:   outstanding_d = outstanding_q + 2'd1;
      2'b01:   outstanding_d = outstanding_q - 2'd1;
      default: outstanding_d = outstanding_q;
    endcase
  end

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d               = state_q;
    mpu_status_o          = MPU_OK;
    mpu_err_trans_valid_o = 1'b0;
    // In idle the limit blocks both sides and a refused access blocks the bus
    mpu_block_core_o      = at_limit;
    mpu_block_bus_o       = at_limit || pma_err_i;

    case (state_q)
      MPU_IDLE: begin
        // Refused access taken from the core and never sent to the bus
        if (core_accept && pma_err_i) begin
          state_d = MPU_ERR_WAIT;
        end
      end

      MPU_ERR_WAIT: begin
        mpu_block_core_o = 1'b1;
        mpu_block_bus_o  = 1'b1;
        // Error response once all earlier responses are back
        if (drained) begin
          mpu_err_trans_valid_o = 1'b1;
          mpu_status_o          = MPU_ERR;
          state_d               = MPU_IDLE;
        end
      end

      default: begin
        state_d = MPU_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= MPU_IDLE;
      outstanding_q <= 2'd0;
    end else begin
      state_q       <= state_d;
      outstanding_q <= outstanding_d;
    end
  end

  assign state_o = state_q;

endmodule

// ==== verilog/mpu_top.sv ====
//////////////////////////////
// MPU top
// PMA check between core and bus
//////////////////////////////
`timescale 1ns/1ps

module mpu_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core side
  input  logic                 core_trans_valid_i,
  output logic                 core_trans_ready_o,
  input  mpu_pkg::core_trans_t core_trans_i,
  output logic                 core_resp_valid_o,
  output mpu_pkg::mpu_resp_t   core_resp_o,

  // Bus side
  output logic                 bus_trans_valid_o,
  input  logic                 bus_trans_ready_i,
  output mpu_pkg::bus_trans_t  bus_trans_o,
  input  logic                 bus_resp_valid_i,
  input  mpu_pkg::mpu_resp_t   bus_resp_i
);

  import mpu_pkg::*;

  pma_attr_t   pma_attr;
  logic        pma_err;
  logic        mpu_block_core;
  logic        mpu_block_bus;
  logic        mpu_err_trans_valid;
  mpu_status_e mpu_status;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  pma_lookup pma_lookup_inst (
    .addr_i    (core_trans_i.addr),
    .size_i    (core_trans_i.size),
    .exec_i    (core_trans_i.exec),
    .atomic_i  (core_trans_i.atomic),
    .attr_o    (pma_attr),
    .pma_err_o (pma_err)
  );

  //////////////////////////////
  // Error FSM
  //////////////////////////////

  mpu_err_fsm mpu_err_fsm_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .core_trans_valid_i    (core_trans_valid_i),
    .core_trans_ready_i    (core_trans_ready_o),
    .bus_trans_valid_i     (bus_trans_valid_o),
    .bus_trans_ready_i     (bus_trans_ready_i),
    .bus_resp_valid_i      (bus_resp_valid_i),
    .pma_err_i             (pma_err),
    .state_o               (),
    .mpu_status_o          (mpu_status),
    .mpu_err_trans_valid_o (mpu_err_trans_valid),
    .mpu_block_core_o      (mpu_block_core),
    .mpu_block_bus_o       (mpu_block_bus)
  );

  //////////////////////////////
  // Request gating
  //////////////////////////////

  assign bus_trans_valid_o = core_trans_valid_i && !mpu_block_bus;

  // A refused access is taken at once, an allowed one waits for the bus
  assign core_trans_ready_o = !mpu_block_core && (pma_err || bus_trans_ready_i);

  // Bus request with memtype from the matched region
  always_comb begin
    bus_trans_o.addr    = core_trans_i.addr;
    bus_trans_o.wdata   = core_trans_i.wdata;
    bus_trans_o.we      = core_trans_i.we;
    bus_trans_o.size    = core_trans_i.size;
    bus_trans_o.memtype = {pma_attr.cacheable, pma_attr.bufferable};
  end

  //////////////////////////////
  // Response select
  //////////////////////////////

  // The FSM answers only once the bus has drained so the two never overlap
  assign core_resp_valid_o = bus_resp_valid_i || mpu_err_trans_valid;

  always_comb begin
    if (mpu_err_trans_valid) begin
      core_resp_o.rdata = '0;
      core_resp_o.err   = (mpu_status == MPU_ERR);
    end else begin
      core_resp_o = bus_resp_i;
    end
  end

endmodule

// ==== sim/bus_mem_model.sv ====
//////////////////////////////
// Bus memory model
// Word memory with one wait state
//////////////////////////////
`timescale 1ns/1ps

module bus_mem_model (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                bus_trans_valid_i,
  output logic                bus_trans_ready_o,
  input  mpu_pkg::bus_trans_t bus_trans_i,
  output logic                bus_resp_valid_o,
  output mpu_pkg::mpu_resp_t  bus_resp_o
);

  import mpu_pkg::*;

  logic [31:0] mem [logic [29:0]];
  logic        ready_q;
  logic [29:0] word_addr;

  assign word_addr         = bus_trans_i.addr[31:2];
  assign bus_trans_ready_o = ready_q;

  // Unwritten words read back a pattern built from the whole address
  function automatic logic [31:0] fill_word(input logic [29:0] waddr);
    return {waddr, 2'b00} ^ 32'h5A5A_A5A5;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q          <= 1'b0;
      bus_resp_valid_o <= 1'b0;
      bus_resp_o       <= '0;
    end else begin
      bus_resp_valid_o <= 1'b0;
      bus_resp_o       <= '0;
      if (bus_trans_valid_i && ready_q) begin
        // Answer next cycle and drop ready again
        ready_q          <= 1'b0;
        bus_resp_valid_o <= 1'b1;
        if (bus_trans_i.we) begin
          mem[word_addr] = bus_trans_i.wdata;
        end else if (mem.exists(word_addr)) begin
          bus_resp_o.rdata <= mem[word_addr];
        end else begin
          bus_resp_o.rdata <= fill_word(word_addr);
        end
      end else if (bus_trans_valid_i) begin
        // One wait cycle before each acceptance
        ready_q <= 1'b1;
      end
    end
  end

endmodule

// ==== sim/mpu_assertions.sv ====
//////////////////////////////
// MPU checker
// Region table and FSM properties
//////////////////////////////
`timescale 1ns/1ps
`include "mpu_cfg.svh"

module mpu_assertions (
  input logic                clk,
  input logic                rst_n,
  input mpu_pkg::mpu_state_e state_i,
  input logic [1:0]          outstanding_i,
  input logic                block_core_i,
  input logic                bus_resp_valid_i,
  input logic                err_trans_valid_i
);

  import mpu_pkg::*;

  // Main memory takes atomics, I/O is never cached
  function automatic logic attr_ok(input pma_attr_t attr);
    return (!attr.main || attr.atomic) && (attr.main || !attr.cacheable);
  endfunction

  initial begin
    assert (attr_ok(`MPU_R0_ATTR)) else $error("Region 0 attributes break the main/I/O rules");
    assert (attr_ok(`MPU_R1_ATTR)) else $error("Region 1 attributes break the main/I/O rules");
    assert (attr_ok(`MPU_R2_ATTR)) else $error("Region 2 attributes break the main/I/O rules");
    assert (attr_ok(`MPU_R3_ATTR)) else $error("Region 3 attributes break the main/I/O rules");
  end

  // Both responses share the core channel
  assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_resp_valid_i && err_trans_valid_i))
    else $error("Bus response and error response in the same cycle");

  assert property (@(posedge clk) disable iff (!rst_n)
    block_core_i |-> (state_i != MPU_IDLE) || (outstanding_i == `MPU_MAX_OUTSTANDING))
    else $error("Core blocked in idle below the outstanding limit");

endmodule

bind mpu_err_fsm mpu_assertions mpu_assertions_inst (
  .clk               (clk),
  .rst_n             (rst_n),
  .state_i           (state_q),
  .outstanding_i     (outstanding_q),
  .block_core_i      (mpu_block_core_o),
  .bus_resp_valid_i  (bus_resp_valid_i),
  .err_trans_valid_i (mpu_err_trans_valid_o)
);

// ==== sim/mpu_top_tb.sv ====
//////////////////////////////
// MPU testbench
// Table driven checks against a bus memory model
//////////////////////////////
`timescale 1ns/1ps

module mpu_top_tb;

  import mpu_pkg::*;

  // Stimulus row with the response and memtype it should give
  typedef struct packed {
    core_trans_t trans;
    mpu_resp_t   resp;
    logic [1:0]  memtype;
    logic        bus_used;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        core_trans_valid_i;
  logic        core_trans_ready_o;
  core_trans_t core_trans_i;
  logic        core_resp_valid_o;
  mpu_resp_t   core_resp_o;
  logic        bus_trans_valid_o;
  logic        bus_trans_ready_i;
  bus_trans_t  bus_trans_o;
  logic        bus_resp_valid_i;
  mpu_resp_t   bus_resp_i;

  row_t rows [$];
  int   row_errors [$];
  int   pending_q [$];
  int   error_count = 0;
  int   check_count = 0;
  int   responses = 0;
  int   bus_handshakes = 0;
  int   expected_bus = 0;
  int   stall_cycles = 0;
  int   cycles = 0;
  int   timeout_limit = 0;
  int   cur_row = 0;
  int   seed = 37;

  always #20 clk = ~clk;

  mpu_top mpu_top_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_trans_i       (core_trans_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_trans_o        (bus_trans_o),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_i         (bus_resp_i)
  );

  bus_mem_model bus_mem_model_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_trans_valid_i (bus_trans_valid_o),
    .bus_trans_ready_o (bus_trans_ready_i),
    .bus_trans_i       (bus_trans_o),
    .bus_resp_valid_o  (bus_resp_valid_i),
    .bus_resp_o        (bus_resp_i)
  );

  //////////////////////////////
  // Table helpers
  //////////////////////////////

  function automatic core_trans_t word_access(input logic [31:0] addr, input logic we,
                                              input logic [31:0] wdata);
    core_trans_t t;
    t       = '0;
    t.addr  = addr;
    t.wdata = wdata;
    t.we    = we;
    t.size  = 2'd2;
    return t;
  endfunction

  // Memory model contents for a word never written
  function automatic logic [31:0] expected_fill(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic add_row(input core_trans_t trans, input logic [31:0] rdata, input logic err,
                         input logic [1:0] memtype);
    row_t r;
    r.trans      = trans;
    r.resp.rdata = rdata;
    r.resp.err   = err;
    r.memtype    = memtype;
    r.bus_used   = !err;
    rows.push_back(r);
    row_errors.push_back(0);
    if (!err) begin
      expected_bus++;
    end
  endtask

  task automatic build_table();
    core_trans_t t;
    logic [31:0] shuffle_addr [4];
    logic [1:0]  shuffle_mt [4];
    int          order [4];
    int          j;
    int          tmp;

    // Region 0 and region 1 data path
    add_row(word_access(32'h0000_1000, 1'b1, 32'h1111_2222), '0, 1'b0, 2'd3);
    add_row(word_access(32'h0000_1000, 1'b0, '0), 32'h1111_2222, 1'b0, 2'd3);
    add_row(word_access(32'h0000_5000, 1'b1, 32'h5555_AAAA), '0, 1'b0, 2'd1);
    add_row(word_access(32'h0000_5000, 1'b0, '0), 32'h5555_AAAA, 1'b0, 2'd1);
    // Overlap of regions 0 and 1
    add_row(word_access(32'h0000_3000, 1'b1, 32'h3333_CCCC), '0, 1'b0, 2'd3);
    add_row(word_access(32'h0000_3000, 1'b0, '0), 32'h3333_CCCC, 1'b0, 2'd3);
    // Refused accesses
    t = word_access(32'h1000_0010, 1'b0, '0);
    t.exec = 1'b1;
    add_row(t, '0, 1'b1, 2'd0);
    t = word_access(32'h2000_0001, 1'b0, '0);
    t.size = 2'd1;
    add_row(t, '0, 1'b1, 2'd0);
    t = word_access(32'h1000_0000, 1'b0, '0);
    t.atomic = 1'b1;
    add_row(t, '0, 1'b1, 2'd0);
    t = word_access(32'h3000_0000, 1'b0, '0);
    t.exec = 1'b1;
    add_row(t, '0, 1'b1, 2'd0);
    t = word_access(32'h3000_0004, 1'b1, 32'hDEAD_0004);
    t.atomic = 1'b1;
    add_row(t, '0, 1'b1, 2'd0);
    // Allowed I/O read, atomics and a fetch from main memory
    add_row(word_access(32'h1000_0020, 1'b0, '0), expected_fill(32'h1000_0020), 1'b0, 2'd1);
    t = word_access(32'h0000_0100, 1'b1, 32'hA70A_0100);
    t.atomic = 1'b1;
    add_row(t, '0, 1'b0, 2'd3);
    t = word_access(32'h0000_0100, 1'b0, '0);
    t.atomic = 1'b1;
    add_row(t, 32'hA70A_0100, 1'b0, 2'd3);
    t = word_access(32'h0000_1000, 1'b0, '0);
    t.exec = 1'b1;
    add_row(t, 32'h1111_2222, 1'b0, 2'd3);
    // Two reads, then a misaligned I/O write that must answer last
    add_row(word_access(32'h0000_1000, 1'b0, '0), 32'h1111_2222, 1'b0, 2'd3);
    add_row(word_access(32'h0000_5000, 1'b0, '0), 32'h5555_AAAA, 1'b0, 2'd1);
    add_row(word_access(32'h1000_0022, 1'b1, 32'h0BAD_0022), '0, 1'b1, 2'd0);
    // Back to back writes and read back in shuffled order
    shuffle_addr = '{32'h0000_0200, 32'h0000_6000, 32'h0000_3FFC, 32'h1000_0FF0};
    shuffle_mt   = '{2'd3, 2'd1, 2'd3, 2'd1};
    order        = '{0, 1, 2, 3};
    for (int k = 3; k > 0; k--) begin
      j        = $unsigned($random(seed)) % (k + 1);
      tmp      = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 4; k++) begin
      add_row(word_access(shuffle_addr[k], 1'b1, ~shuffle_addr[k]), '0, 1'b0, shuffle_mt[k]);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(word_access(shuffle_addr[order[k]], 1'b0, '0), ~shuffle_addr[order[k]], 1'b0,
              shuffle_mt[order[k]]);
    end
    timeout_limit = rows.size() * 20;
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_resp(input mpu_resp_t got, input mpu_resp_t exp, input int row);
    check_count++;
    if (got !== exp) begin
      $display("CHECK FAILED core_resp_o row %0d: got %h, expected %h", row, got, exp);
      error_count++;
      row_errors[row]++;
    end
  endtask

  task automatic check_memtype(input logic [1:0] got, input logic [1:0] exp, input int row);
    check_count++;
    if (got !== exp) begin
      $display("CHECK FAILED bus_trans_o.memtype row %0d: got %h, expected %h", row, got, exp);
      error_count++;
      row_errors[row]++;
    end
  endtask

  // Address, data, direction and size pass through unchanged
  task automatic check_bus_trans(input bus_trans_t got, input bus_trans_t exp, input int row);
    check_count++;
    if ((got.addr !== exp.addr) || (got.wdata !== exp.wdata) || (got.we !== exp.we) ||
        (got.size !== exp.size)) begin
      $display("CHECK FAILED bus_trans_o row %0d: got %h, expected %h", row, got, exp);
      error_count++;
      row_errors[row]++;
    end
  endtask

  //////////////////////////////
  // Drive and watch
  //////////////////////////////

  initial begin
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      cur_row            = i;
      core_trans_i       = rows[i].trans;
      core_trans_valid_i = 1'b1;
      @(posedge clk);
      while (core_trans_ready_o !== 1'b1) @(posedge clk);
      @(negedge clk);
    end
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
  end

  always @(posedge clk) begin : watch_ports
    int         idx;
    bus_trans_t exp_bus;
    if (rst_n === 1'b1) begin
      if (bus_trans_valid_o && !bus_trans_ready_i) begin
        stall_cycles++;
      end
      if (bus_trans_valid_o && bus_trans_ready_i) begin
        bus_handshakes++;
        if (!rows[cur_row].bus_used) begin
          $display("Row %0d: refused access reached the bus", cur_row);
          error_count++;
          row_errors[cur_row]++;
        end else begin
          exp_bus         = '0;
          exp_bus.addr    = rows[cur_row].trans.addr;
          exp_bus.wdata   = rows[cur_row].trans.wdata;
          exp_bus.we      = rows[cur_row].trans.we;
          exp_bus.size    = rows[cur_row].trans.size;
          exp_bus.memtype = rows[cur_row].memtype;
          check_bus_trans(bus_trans_o, exp_bus, cur_row);
          check_memtype(bus_trans_o.memtype, rows[cur_row].memtype, cur_row);
        end
      end
      if (core_resp_valid_o) begin
        if (pending_q.size() == 0) begin
          $display("Core response arrived with no transaction waiting");
          error_count++;
        end else begin
          idx = pending_q.pop_front();
          check_resp(core_resp_o, rows[idx].resp, idx);
          responses++;
          $display("Row %2d addr %h: %s", idx, rows[idx].trans.addr,
                   (row_errors[idx] == 0) ? "ok" : "FAILED");
        end
      end
      // Issue order is the order responses must come back in
      if (core_trans_valid_i && core_trans_ready_o) begin
        pending_q.push_back(cur_row);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (rst_n === 1'b1 && cycles > timeout_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d responses", cycles, responses,
               rows.size());
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    wait (rst_n === 1'b1);
    wait (responses == rows.size());
    repeat (4) @(posedge clk);
    if (bus_handshakes != expected_bus) begin
      $display("Bus saw %0d requests instead of %0d", bus_handshakes, expected_bus);
      error_count++;
    end
    if (stall_cycles == 0) begin
      $display("The bus never held a request back");
      error_count++;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", rows.size(), check_count,
             error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== mpu_top.f ====
+incdir+verilog
verilog/mpu_pkg.sv
verilog/pma_lookup.sv
verilog/mpu_err_fsm.sv
verilog/mpu_top.sv
sim/bus_mem_model.sv
sim/mpu_assertions.sv
sim/mpu_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mpu_top_tb -f mpu_top.f -o mpu_top_sim

output=$(./obj_dir/mpu_top_sim)
echo "$output"

if echo "$output" | grep -q "^Testbench passed$"; then
  exit 0
else
  exit 1
fi
